/* flist.f */
+incdir+include
design/av_config_pkg.sv
design/av_config_clock_div.sv
design/av_config_init_rom.sv
design/av_config_regs.sv
design/av_config_serial_shifter.sv
design/av_config_ctrl_fsm.sv
design/av_config_top.sv
dv/av_config_codec_model.sv
dv/av_config_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= av_config_tb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(BUILD_DIR)

/* dv/av_config_tb.sv */
`include "av_config_settings.svh"

module av_config_tb;
	import av_config_pkg::*;

	localparam int POLL_LIMIT = 60000;
	localparam int WAIT_LIMIT = 2000;

	logic       clk;
	logic       rst;
	logic [1:0] address;
	logic [3:0] byteenable;
	logic       read;
	logic       write;
	bus_word_t  writedata;
	bus_word_t  readdata;
	logic       waitrequest;
	logic       irq;
	logic       sclk;
	logic       scen;
	logic       dut_oe;
	logic       model_oe;
	logic       sda_line;
	logic       refuse;

	int         seed;
	int         test_errs;
	int         pass_cnt;
	int         fail_cnt;
	logic       timed_out;
	event       timeout_ev;

	// Open-drain line pulled low by either side
	assign sda_line = !(dut_oe || model_oe);

	av_config_top uut (
		.clk(clk), .rst(rst), .address(address), .byteenable(byteenable),
		.read(read), .write(write), .writedata(writedata), .readdata(readdata),
		.waitrequest(waitrequest), .irq(irq), .i2c_sclk(sclk), .i2c_scen(scen),
		.i2c_sdat_oe(dut_oe), .i2c_sdat_in(sda_line)
	);

	av_config_codec_model codec (
		.scl(sclk), .sda(sda_line), .refuse(refuse), .sda_oe(model_oe)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// Expected codec value for table entry n
	function automatic codec_val_t expected_init(input int n);
		case (n)
			0: return `AV_LINE_IN_LC;
			1: return `AV_LINE_IN_RC;
			2: return `AV_LINE_OUT_LC;
			3: return `AV_LINE_OUT_RC;
			4: return `AV_ADC_PATH;
			5: return `AV_DAC_PATH;
			6: return `AV_POWER;
			7: return `AV_DATA_FORMAT;
			8: return `AV_SAMPLE_CTRL;
			default: return `AV_SET_ACTIVE;
		endcase
	endfunction

	always @(timeout_ev) begin
		$display("TEST FAILED");
		$finish;
	end

	task automatic report_timeout(input string what);
		$display("Timed out waiting for %s", what);
		timed_out = 1'b1;
		-> timeout_ev;
	endtask

	task automatic check_value(input string name, input bus_word_t exp, input bus_word_t act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic close_test(input string name);
		if (test_errs == 0) begin
			pass_cnt++;
			$display("PASS %s", name);
		end else begin
			fail_cnt++;
			$display("FAIL %s with %0d errors", name, test_errs);
		end
		test_errs = 0;
	endtask

	// Hold the strobe until waitrequest is low
	task automatic bus_write(input logic [1:0] addr, input bus_word_t data, input logic [3:0] be);
		int n;
		n = 0;
		@(negedge clk);
		address    = addr;
		writedata  = data;
		byteenable = be;
		write      = 1'b1;
		#1;
		while (waitrequest && n < WAIT_LIMIT) begin
			@(negedge clk);
			#1;
			n++;
		end
		if (n >= WAIT_LIMIT) begin
			report_timeout("waitrequest to fall");
		end
		@(negedge clk);
		write = 1'b0;
	endtask

	task automatic bus_read(input logic [1:0] addr, output bus_word_t data);
		@(negedge clk);
		address = addr;
		read    = 1'b1;
		@(negedge clk);
		read = 1'b0;
		data = readdata;
	endtask

	task automatic wait_ready();
		bus_word_t st;
		int n;
		n = 0;
		st = '0;
		while (!st[1] && n < POLL_LIMIT) begin
			bus_read(2'd1, st);
			n++;
		end
		if (!st[1]) begin
			report_timeout("status ready");
		end
	endtask

	// Serial enable drops once the frame begins
	task automatic wait_frame_start();
		int n;
		n = 0;
		while (scen && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (scen) begin
			report_timeout("serial enable to fall");
		end
	endtask

	task automatic check_table(input string name);
		for (int i = 0; i < `AV_INIT_SIZE; i++) begin
			check_value(name, 32'(expected_init(i)), 32'(codec.regs[i]));
		end
	endtask

	// Upper data bits set so readback shows they are dropped
	task automatic host_transfer(input codec_reg_t idx, input codec_val_t val);
		bus_write(2'd2, 32'(idx), 4'h1);
		bus_write(2'd3, 32'hFFFF_FE00 | 32'(val), 4'h3);
		wait_ready();
	endtask

	initial begin
		bus_word_t  rd;
		bus_word_t  r;
		codec_reg_t idx;
		codec_val_t val;
		seed       = 32'h3b2d;
		test_errs  = 0;
		pass_cnt   = 0;
		fail_cnt   = 0;
		timed_out  = 1'b0;
		address    = '0;
		byteenable = '0;
		read       = 1'b0;
		write      = 1'b0;
		writedata  = '0;
		refuse     = 1'b0;
		rst        = 1'b1;
		repeat (3) @(negedge clk);
		rst = 1'b0;

		// Auto-init fills the codec
		wait_ready();
		check_table("auto_init");
		bus_read(2'd1, rd);
		check_value("auto_init_ok", 32'h1, 32'(rd[8]));
		check_value("auto_init_ack_err", 32'h0, 32'(rd[0]));
		// Serial pins back at rest
		check_value("idle_sclk", 32'h1, 32'(sclk));
		check_value("idle_sdat_oe", 32'h0, 32'(dut_oe));
		check_value("idle_scen", 32'h1, 32'(scen));
		close_test("auto_init");

		// Readback with unused bits at 0
		bus_write(2'd0, 32'hFFFF_FFFE, 4'hF);
		bus_read(2'd0, rd);
		check_value("ctrl_readback", 32'h2, rd);
		bus_write(2'd2, 32'hFFFF_FFFF, 4'hF);
		bus_read(2'd2, rd);
		check_value("index_readback", 32'h7F, rd);
		bus_read(2'd1, rd);
		check_value("status_readback", 32'h0002_0102, rd);
		bus_write(2'd0, 32'h0, 4'hF);
		close_test("readback");

		// Random host transfers
		for (int k = 0; k < 4; k++) begin
			r   = $random(seed);
			idx = r[6:0];
			r   = $random(seed);
			val = r[8:0];
			host_transfer(idx, val);
			check_value("xfer_model", 32'(val), 32'(codec.regs[idx]));
			bus_read(2'd3, rd);
			check_value("xfer_data_readback", 32'(val), rd);
		end
		close_test("host_transfers");

		// Refused ack sets the sticky flag and a good transfer clears it
		refuse = 1'b1;
		host_transfer(7'd5, 9'h0AA);
		bus_read(2'd1, rd);
		check_value("refused_ack_err", 32'h1, 32'(rd[0]));
		check_value("refused_init_ok", 32'h1, 32'(rd[8]));
		refuse = 1'b0;
		host_transfer(7'd5, 9'h006);
		bus_read(2'd1, rd);
		check_value("recovered_ack_err", 32'h0, 32'(rd[0]));
		close_test("refused_ack");

		// Irq follows ready when enabled
		bus_write(2'd0, 32'h2, 4'h1);
		check_value("irq_idle", 32'h1, 32'(irq));
		bus_write(2'd2, 32'h3, 4'h1);
		bus_write(2'd3, 32'h055, 4'h3);
		check_value("irq_busy", 32'h0, 32'(irq));
		wait_frame_start();
		check_value("irq_frame", 32'h0, 32'(irq));
		wait_ready();
		@(negedge clk);
		check_value("irq_done", 32'h1, 32'(irq));
		check_value("scen_done", 32'h1, 32'(scen));
		bus_write(2'd0, 32'h0, 4'h1);
		close_test("interrupt");

		// Soft reset reruns auto-init
		codec.clear_regs();
		bus_write(2'd0, 32'h1, 4'h1);
		wait_ready();
		check_table("soft_reset");
		close_test("soft_reset");

		$display("Tests passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && !timed_out) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* dv/av_config_codec_model.sv */
module av_config_codec_model (
	input  logic scl,
	input  logic sda,
	input  logic refuse,
	output logic sda_oe
);
	import av_config_pkg::*;

	codec_val_t regs [0:127];
	logic       active;
	logic       nacked;
	logic [3:0] bit_cnt;
	logic [1:0] byte_cnt;
	logic [7:0] shift;
	logic [7:0] bytes [0:2];

	initial begin
		sda_oe   = 1'b0;
		active   = 1'b0;
		nacked   = 1'b0;
		bit_cnt  = '0;
		byte_cnt = '0;
		shift    = '0;
		for (int i = 0; i < 128; i++) begin
			regs[i] = '0;
		end
	end

	// Start condition, data falls while clock high
	always @(negedge sda) begin
		if (scl === 1'b1) begin
			active   = 1'b1;
			bit_cnt  = '0;
			byte_cnt = '0;
			// Refuse is latched for the whole frame
			nacked   = refuse;
		end
	end

	// Stop condition commits a complete, acknowledged write
	always @(posedge sda) begin
		if (scl === 1'b1 && active) begin
			active = 1'b0;
			if (byte_cnt == 2'd3 && !nacked && bytes[0] == `AV_DEV_ADDR) begin
				regs[bytes[1][7:1]] = {bytes[1][0], bytes[2]};
			end
		end
	end

	// Bits are sampled on the rising clock
	always @(posedge scl) begin
		if (active) begin
			if (bit_cnt != 4'd8) begin
				shift   = {shift[6:0], sda};
				bit_cnt = bit_cnt + 4'd1;
				if (bit_cnt == 4'd8 && byte_cnt != 2'd3) begin
					bytes[byte_cnt] = shift;
				end
			end else begin
				// Ack clock
				bit_cnt  = '0;
				byte_cnt = byte_cnt + 2'd1;
			end
		end
	end

	// Pull low for the ack slot, release after it
	always @(negedge scl) begin
		sda_oe = active && (bit_cnt == 4'd8) && !nacked;
	end

	task automatic clear_regs();
		for (int i = 0; i < 128; i++) begin
			regs[i] = '0;
		end
	endtask

endmodule

/* design/av_config_top.sv */
module av_config_top (
	input  logic                     clk,
	input  logic                     rst,
	input  logic [1:0]               address,
	input  logic [3:0]               byteenable,
	input  logic                     read,
	input  logic                     write,
	input  av_config_pkg::bus_word_t writedata,
	output av_config_pkg::bus_word_t readdata,
	output logic                     waitrequest,
	output logic                     irq,
	output logic                     i2c_sclk,
	output logic                     i2c_scen,
	output logic                     i2c_sdat_oe,
	input  logic                     i2c_sdat_in
);
	import av_config_pkg::*;

	logic       soft_rst;
	logic       rst_i;
	logic       wr_go;
	logic       pre_write;
	logic       ready;
	logic       init_ok;
	logic       xfer_done;
	logic       start;
	logic       done;
	logic       ack_err;
	logic       clk_en;
	logic       tick;
	codec_reg_t host_reg;
	codec_val_t host_val;
	codec_reg_t rom_reg;
	codec_val_t rom_val;
	init_idx_t  init_idx;
	frame_t     frame;

	// Board reset or control bit 0
	assign rst_i = rst | soft_rst;

	av_config_regs u_regs (
		.clk(clk), .rst(rst_i), .address(address), .byteenable(byteenable),
		.read(read), .write(write), .writedata(writedata), .readdata(readdata),
		.waitrequest(waitrequest), .irq(irq), .soft_rst(soft_rst),
		.pre_write(pre_write), .ready(ready), .init_ok(init_ok),
		.xfer_done(xfer_done), .xfer_ack_err(ack_err),
		.host_reg(host_reg), .host_val(host_val), .wr_go(wr_go)
	);

	av_config_ctrl_fsm u_fsm (
		.clk(clk), .rst(rst_i), .wr_go(wr_go), .host_reg(host_reg),
		.host_val(host_val), .done(done), .ack_err(ack_err), .start(start),
		.frame(frame), .init_idx(init_idx), .rom_reg(rom_reg), .rom_val(rom_val),
		.ready(ready), .init_ok(init_ok), .pre_write(pre_write), .xfer_done(xfer_done)
	);

	av_config_init_rom u_rom (.idx(init_idx), .reg_addr(rom_reg), .reg_val(rom_val));

	av_config_clock_div u_div (.clk(clk), .rst(rst_i), .en(clk_en), .tick(tick));

	// Done marks the end of a frame
	av_config_serial_shifter u_shift (
		.clk(clk), .rst(rst_i), .start(start), .frame(frame), .tick(tick),
		.clk_en(clk_en), .busy(), .done(done), .ack_err(ack_err),
		.sclk(i2c_sclk), .sdat_oe(i2c_sdat_oe), .scen(i2c_scen), .sdat_in(i2c_sdat_in)
	);

endmodule

/* design/av_config_ctrl_fsm.sv */
`include "av_config_settings.svh"

module av_config_ctrl_fsm (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      wr_go,
	input  av_config_pkg::codec_reg_t host_reg,
	input  av_config_pkg::codec_val_t host_val,
	input  logic                      done,
	input  logic                      ack_err,
	output logic                      start,
	output av_config_pkg::frame_t     frame,
	output av_config_pkg::init_idx_t  init_idx,
	input  av_config_pkg::codec_reg_t rom_reg,
	input  av_config_pkg::codec_val_t rom_val,
	output logic                      ready,
	output logic                      init_ok,
	output logic                      pre_write,
	output logic                      xfer_done
);
	import av_config_pkg::*;

	localparam init_idx_t LAST_IDX = init_idx_t'(`AV_INIT_SIZE - 1);

	xfer_state_t state_q;
	xfer_state_t state_d;
	logic        init_err_q;
	logic        in_init;
	codec_reg_t  frame_reg;
	codec_val_t  frame_val;

	always_comb begin
		state_d = state_q;
		case (state_q)
			INIT_LOAD: state_d = INIT_SEND;
			INIT_SEND: if (done) state_d = INIT_NEXT;
			INIT_NEXT: state_d = (init_idx == LAST_IDX) ? IDLE : INIT_LOAD;
			IDLE: if (wr_go) state_d = PRE_WRITE;
			PRE_WRITE: state_d = WRITE_SEND;
			WRITE_SEND: if (done) state_d = POST_WRITE;
			POST_WRITE: state_d = IDLE;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q    <= INIT_LOAD;
			init_idx   <= '0;
			init_err_q <= 1'b0;
			start      <= 1'b0;
		end else begin
			state_q <= state_d;
			// Start lands in the first cycle of a send state
			start <= (state_q == INIT_LOAD) || (state_q == PRE_WRITE);
			if ((state_q == INIT_NEXT) && (init_idx != LAST_IDX)) begin
				init_idx <= init_idx + 1'b1;
			end
			// Any refused table entry
			if ((state_q == INIT_SEND) && done && ack_err) begin
				init_err_q <= 1'b1;
			end
		end
	end

	assign in_init   = (state_q == INIT_LOAD) || (state_q == INIT_SEND) ||
	                   (state_q == INIT_NEXT);
	assign ready     = (state_q == IDLE);
	assign init_ok   = !in_init && !init_err_q;
	assign pre_write = (state_q == PRE_WRITE);
	assign xfer_done = (state_q == WRITE_SEND) && done;

	// Table entry during init, host registers afterwards
	assign frame_reg = in_init ? rom_reg : host_reg;
	assign frame_val = in_init ? rom_val : host_val;

	// Device byte, index with value MSB, low value byte, ack slots released
	assign frame = {`AV_DEV_ADDR, 1'b1, frame_reg, frame_val[8], 1'b1,
	                frame_val[7:0], 1'b1};

endmodule

/* design/av_config_serial_shifter.sv */
module av_config_serial_shifter (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	input  av_config_pkg::frame_t frame,
	input  logic                  tick,
	output logic                  clk_en,
	output logic                  busy,
	output logic                  done,
	output logic                  ack_err,
	output logic                  sclk,
	output logic                  sdat_oe,
	output logic                  scen,
	input  logic                  sdat_in
);
	import av_config_pkg::*;

	// Slot 0 is the start condition, 1 to 27 the frame, 28 the stop
	localparam logic [4:0] LAST_BIT  = 5'd27;
	localparam logic [4:0] STOP_SLOT = 5'd28;

	frame_t     shift_q;
	logic [4:0] slot_q;
	logic [1:0] phase_q;
	logic       ack_slot;
	logic       bit_slot;

	// Ack follows each byte
	assign ack_slot = (slot_q == 5'd9) || (slot_q == 5'd18) || (slot_q == LAST_BIT);
	assign bit_slot = (slot_q != 5'd0) && (slot_q != STOP_SLOT);

	// Divider only runs during a frame
	assign clk_en = busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy    <= 1'b0;
			done    <= 1'b0;
			ack_err <= 1'b0;
			sclk    <= 1'b1;
			sdat_oe <= 1'b0;
			scen    <= 1'b1;
			slot_q  <= '0;
			phase_q <= '0;
		end else begin
			done <= 1'b0;
			if (!busy) begin
				if (start) begin
					busy    <= 1'b1;
					scen    <= 1'b0;
					ack_err <= 1'b0;
					slot_q  <= '0;
					phase_q <= '0;
				end
			end else if (tick) begin
				phase_q <= phase_q + 2'd1;
				if (phase_q == 2'd3) begin
					slot_q <= slot_q + 5'd1;
				end
				if (slot_q == 5'd0) begin
					// Data falls while clock high, then clock drops
					if (phase_q == 2'd0) begin
						sdat_oe <= 1'b1;
					end
					if (phase_q == 2'd2) begin
						sclk <= 1'b0;
					end
				end else if (slot_q == STOP_SLOT) begin
					// Data low, clock up, then data released while high
					if (phase_q == 2'd0) begin
						sdat_oe <= 1'b1;
					end
					if (phase_q == 2'd1) begin
						sclk <= 1'b1;
					end
					if (phase_q == 2'd2) begin
						sdat_oe <= 1'b0;
					end
					if (phase_q == 2'd3) begin
						busy <= 1'b0;
						done <= 1'b1;
						scen <= 1'b1;
					end
				end else begin
					case (phase_q)
						// Set data while clock is low
						2'd0: sdat_oe <= !ack_slot && !shift_q[26];
						2'd1: sclk <= 1'b1;
						// Mid-high sample, high in an ack slot means refused
						2'd2: ack_err <= ack_err | (ack_slot & sdat_in);
						default: sclk <= 1'b0;
					endcase
				end
			end
		end
	end

	// Frame shift register, MSB goes out first
	always_ff @(posedge clk) begin
		if (!busy && start) begin
			shift_q <= frame;
		end else if (busy && tick && bit_slot && (phase_q == 2'd3)) begin
			shift_q <= {shift_q[25:0], 1'b0};
		end
	end

endmodule

/* design/av_config_regs.sv */
`include "av_config_settings.svh"

module av_config_regs (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [1:0]                address,
	input  logic [3:0]                byteenable,
	input  logic                      read,
	input  logic                      write,
	input  av_config_pkg::bus_word_t  writedata,
	output av_config_pkg::bus_word_t  readdata,
	output logic                      waitrequest,
	output logic                      irq,
	output logic                      soft_rst,
	input  logic                      pre_write,
	input  logic                      ready,
	input  logic                      init_ok,
	input  logic                      xfer_done,
	input  logic                      xfer_ack_err,
	output av_config_pkg::codec_reg_t host_reg,
	output av_config_pkg::codec_val_t host_val,
	output logic                      wr_go
);
	import av_config_pkg::*;

	logic       irq_en_q;
	logic       ack_err_q;
	codec_reg_t idx_q;
	codec_val_t data_q;
	logic       wr_acc;
	bus_word_t  status;

	// Data writes stall until the sequencer reaches PRE_WRITE
	assign waitrequest = write && (address == 2'd3) && !pre_write;
	assign wr_acc      = write && !waitrequest;

	// Any write to the data register, the sequencer filters by state
	assign wr_go = write && (address == 2'd3);

	// Control bit 0 resets the whole block for one cycle
	assign soft_rst = write && (address == 2'd0) && byteenable[0] && writedata[0];

	assign irq = irq_en_q && ready;

	assign status = {8'h00, `AV_CFG_TYPE, 7'h00, init_ok, 6'h00, ready, ack_err_q};

	// Control and index registers
	always_ff @(posedge clk) begin
		if (rst) begin
			irq_en_q <= 1'b0;
			idx_q    <= '0;
		end else if (wr_acc && byteenable[0]) begin
			if (address == 2'd0) begin
				irq_en_q <= writedata[1];
			end
			if (address == 2'd2) begin
				idx_q <= writedata[6:0];
			end
		end
	end

	// Value to send, low byte and top bit on separate lanes
	always_ff @(posedge clk) begin
		if (wr_acc && (address == 2'd3)) begin
			if (byteenable[0]) begin
				data_q[7:0] <= writedata[7:0];
			end
			if (byteenable[1]) begin
				data_q[8] <= writedata[8];
			end
		end
	end

	// Last host transfer result, refused ack sets it
	always_ff @(posedge clk) begin
		if (rst) begin
			ack_err_q <= 1'b0;
		end else if (xfer_done) begin
			ack_err_q <= xfer_ack_err;
		end
	end

	// Read data one cycle after the strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			readdata <= '0;
		end else if (read) begin
			case (address)
				2'd0: readdata <= {30'd0, irq_en_q, 1'b0};
				2'd1: readdata <= status;
				2'd2: readdata <= {25'd0, idx_q};
				default: readdata <= {23'd0, data_q};
			endcase
		end
	end

	assign host_reg = idx_q;
	assign host_val = data_q;

endmodule

/* design/av_config_init_rom.sv */
`include "av_config_settings.svh"

module av_config_init_rom (
	input  av_config_pkg::init_idx_t  idx,
	output av_config_pkg::codec_reg_t reg_addr,
	output av_config_pkg::codec_val_t reg_val
);

	// Entry n writes codec register n
	always_comb begin
		reg_addr = {3'b000, idx};
		case (idx)
			4'd0: reg_val = `AV_LINE_IN_LC;
			4'd1: reg_val = `AV_LINE_IN_RC;
			4'd2: reg_val = `AV_LINE_OUT_LC;
			4'd3: reg_val = `AV_LINE_OUT_RC;
			4'd4: reg_val = `AV_ADC_PATH;
			4'd5: reg_val = `AV_DAC_PATH;
			4'd6: reg_val = `AV_POWER;
			4'd7: reg_val = `AV_DATA_FORMAT;
			4'd8: reg_val = `AV_SAMPLE_CTRL;
			4'd9: reg_val = `AV_SET_ACTIVE;
			default: begin
				// Codec reset register
				reg_addr = 7'd15;
				reg_val  = 9'h000;
			end
		endcase
	end

endmodule

/* design/av_config_clock_div.sv */
`include "av_config_settings.svh"

module av_config_clock_div (
	input  logic clk,
	input  logic rst,
	input  logic en,
	output logic tick
);

	// Wide enough to hold AV_SCL_DIV - 1
	localparam int CW = (`AV_SCL_DIV > 1) ? $clog2(`AV_SCL_DIV) : 1;
	localparam logic [CW-1:0] LAST = CW'(`AV_SCL_DIV - 1);

	logic [CW-1:0] cnt_q;

	// Held at zero while idle
	// so the first quarter bit is never short
	always_ff @(posedge clk) begin
		if (rst || !en) begin
			cnt_q <= '0;
		end else if (cnt_q == LAST) begin
			cnt_q <= '0;
		end else begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	// One cycle per quarter bit
	assign tick = en && (cnt_q == LAST);

endmodule

/* design/av_config_pkg.sv */
package av_config_pkg;

	// Host data word
	typedef logic [31:0] bus_word_t;

	// Three bytes, each followed by its ack slot, MSB first
	typedef logic [26:0] frame_t;

	// Codec register index and value
	typedef logic [6:0] codec_reg_t;
	typedef logic [8:0] codec_val_t;

	// Auto-init table index
	typedef logic [3:0] init_idx_t;

	// Transfer sequencer states
	typedef enum logic [2:0] {
		INIT_LOAD,
		INIT_SEND,
		INIT_NEXT,
		IDLE,
		PRE_WRITE,
		WRITE_SEND,
		POST_WRITE
	} xfer_state_t;

endpackage

/* include/av_config_settings.svh */
`ifndef AV_CONFIG_SETTINGS_SVH
`define AV_CONFIG_SETTINGS_SVH

// clk cycles per quarter bit on the serial bus
`define AV_SCL_DIV 4

// Entries in the auto-init table
`define AV_INIT_SIZE 10

// Codec write address and config type code for status
`define AV_DEV_ADDR 8'h34
`define AV_CFG_TYPE 8'h02

// Codec defaults for registers 0 to 9
`define AV_LINE_IN_LC 9'h01A
`define AV_LINE_IN_RC 9'h01A
`define AV_LINE_OUT_LC 9'h07B
`define AV_LINE_OUT_RC 9'h07B
`define AV_ADC_PATH 9'd149
`define AV_DAC_PATH 9'h006
`define AV_POWER 9'h000
`define AV_DATA_FORMAT 9'd65
`define AV_SAMPLE_CTRL 9'd24
`define AV_SET_ACTIVE 9'h001

`endif
